/* Makefile */
# Verilator build and run of the nn_top testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build nn_tb with Verilator, run it and check the result"
	@echo "  clean  remove the Verilator output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module nn_tb -Mdir obj_dir -f build.f
	@out="$$(./obj_dir/Vnn_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+design
design/nn_pkg.sv
design/weight_bank.sv
design/hidden_layer.sv
design/output_neuron.sv
design/infer_ctrl.sv
design/nn_top.sv
verif/nn_tb.sv

/* design/hidden_layer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module hidden_layer (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               en_i,
    input  wire nn_pkg::pixel_vec_t pixels_i,
    input  wire nn_pkg::hidden_row_t weights_i [`NN_HIDDEN],
    output nn_pkg::act_vec_t        act_o
);

    // pixel times weight
    localparam int PROD_W = `NN_PIX_W + `NN_W_W;
    // sum of all products, 15 bits
    localparam int HSUM_W = PROD_W + $clog2(`NN_FANIN);
    // one spare bit so an overflow would show
    localparam int HACC_W = HSUM_W + 1;

    nn_pkg::act_vec_t act_d;
    nn_pkg::act_vec_t act_q;

    genvar j;
    generate
        for (j = 0; j < `NN_HIDDEN; j++) begin : g_neuron
            logic [HACC_W-1:0] acc;

            // unsigned multiply-accumulate over the fan-in
            always_comb begin
                acc = '0;
                for (int i = 0; i < `NN_FANIN; i++) begin
                    acc = acc + (HACC_W'(pixels_i[i]) * HACC_W'(weights_i[j][i]));
                end
            end

            // truncating scale, keep the top bits of the sum
            assign act_d[j] = acc[HSUM_W-1:`NN_ACT_SHIFT];

            a_sum_fits: assert property (
                @(posedge clk_i) disable iff (!rst_i)
                en_i |-> (acc[HSUM_W] == 1'b0)
            ) else $error("hidden sum %0d overflows %0d bits", j, HSUM_W);
        end
    endgenerate

    // activations held until the next start
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            act_q <= '0;
        end else if (en_i) begin
            act_q <= act_d;
        end
    end

    assign act_o = act_q;

endmodule

`default_nettype wire

/* design/infer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module infer_ctrl (
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    input  wire logic            start_i,
    input  wire nn_pkg::target_t target_i,
    output logic                 final_en_o,
    output logic                 loss_en_o,
    output nn_pkg::target_t      target_o,
    output logic                 done_o
);

    logic            v1_q;
    logic            v2_q;
    logic            v3_q;
    nn_pkg::target_t tgt1_q;
    nn_pkg::target_t tgt2_q;

    // one valid bit per stage, a new start may enter every cycle
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else begin
            v1_q <= start_i;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    // target follows its pixels down to the loss stage
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            tgt1_q <= '0;
            tgt2_q <= '0;
        end else begin
            tgt1_q <= target_i;
            tgt2_q <= tgt1_q;
        end
    end

    assign final_en_o = v1_q;
    assign loss_en_o  = v2_q;
    assign target_o   = tgt2_q;
    assign done_o     = v3_q;

    a_done_from_start: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        done_o |-> $past(start_i, 3)
    ) else $error("done without a start three cycles earlier");

endmodule

`default_nettype wire

/* design/nn_consts.svh */
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// inputs per neuron
`define NN_FANIN 8
// hidden neurons
`define NN_HIDDEN 8

`define NN_PIX_W 4
// unsigned 1.7 fixed point
`define NN_W_W 8
`define NN_ACT_W 10
// 15-bit hidden sum down to a 10-bit activation
`define NN_ACT_SHIFT 5

`define NN_SUM_W 23
`define NN_LOSS_W 46
`define NN_TGT_W 4
`define NN_ADDR_W 3

`endif

/* design/nn_pkg.sv */
`default_nettype none

`include "nn_consts.svh"

package nn_pkg;

    // scalar data
    typedef logic [`NN_PIX_W-1:0]  pixel_t;
    typedef logic [`NN_W_W-1:0]    weight_t;
    typedef logic [`NN_ACT_W-1:0]  act_t;

    // weights of one hidden neuron, element i goes with pixel i
    typedef weight_t [`NN_FANIN-1:0] hidden_row_t;

    // one image
    typedef pixel_t [`NN_FANIN-1:0] pixel_vec_t;

    // hidden layer outputs
    typedef act_t [`NN_HIDDEN-1:0] act_vec_t;

    // output neuron results
    typedef logic [`NN_SUM_W-1:0]  sum_t;
    typedef logic [`NN_LOSS_W-1:0] loss_t;
    typedef logic [`NN_TGT_W-1:0]  target_t;

endpackage

`default_nettype wire

/* design/nn_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module nn_top (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,

    // inference request
    input  wire logic                  start_i,
    input  wire nn_pkg::pixel_vec_t    pixels_i,
    input  wire nn_pkg::target_t       target_i,

    // weight loading
    input  wire logic                  hw_wr_en_i,
    input  wire logic                  ow_wr_en_i,
    input  wire logic [`NN_ADDR_W-1:0] w_addr_i,
    input  wire nn_pkg::hidden_row_t   hw_data_i,
    input  wire nn_pkg::weight_t       ow_data_i,

    // results
    output nn_pkg::sum_t               final_o,
    output nn_pkg::loss_t              loss_o,
    output logic                       end_check_o,
    output logic                       done_o
);

    nn_pkg::hidden_row_t hidden_w [`NN_HIDDEN];
    nn_pkg::weight_t     out_w [`NN_HIDDEN];
    nn_pkg::act_vec_t    act;

    logic                final_en;
    logic                loss_en;
    nn_pkg::target_t     target_d2;

    // hidden weights, one row per neuron
    weight_bank #(
        .entry_t (nn_pkg::hidden_row_t)
    ) u_hidden_bank (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (hw_wr_en_i),
        .wr_addr_i (w_addr_i),
        .wr_data_i (hw_data_i),
        .entries_o (hidden_w)
    );

    // output weights, one per activation
    weight_bank #(
        .entry_t (nn_pkg::weight_t)
    ) u_out_bank (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (ow_wr_en_i),
        .wr_addr_i (w_addr_i),
        .wr_data_i (ow_data_i),
        .entries_o (out_w)
    );

    // stage 1 captures on the start strobe itself
    hidden_layer u_hidden_layer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (start_i),
        .pixels_i  (pixels_i),
        .weights_i (hidden_w),
        .act_o     (act)
    );

    output_neuron u_output_neuron (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (final_en),
        .loss_en_i   (loss_en),
        .target_i    (target_d2),
        .act_i       (act),
        .weights_i   (out_w),
        .final_o     (final_o),
        .loss_o      (loss_o),
        .end_check_o (end_check_o)
    );

    infer_ctrl u_infer_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .target_i   (target_i),
        .final_en_o (final_en),
        .loss_en_o  (loss_en),
        .target_o   (target_d2),
        .done_o     (done_o)
    );

endmodule

`default_nettype wire

/* design/output_neuron.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module output_neuron (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             en_i,
    input  wire logic             loss_en_i,
    input  wire nn_pkg::target_t  target_i,
    input  wire nn_pkg::act_vec_t act_i,
    input  wire nn_pkg::weight_t  weights_i [`NN_HIDDEN],
    output nn_pkg::sum_t          final_o,
    output nn_pkg::loss_t         loss_o,
    output logic                  end_check_o
);

    nn_pkg::sum_t  w_ext [`NN_HIDDEN];
    nn_pkg::sum_t  final_d;
    nn_pkg::sum_t  final_q;
    logic signed [`NN_LOSS_W-1:0] diff;
    nn_pkg::loss_t loss_d;
    nn_pkg::loss_t loss_q;

    // weights zero extended to the sum width
    always_comb begin
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            w_ext[j] = nn_pkg::sum_t'(weights_i[j]);
        end
    end

    // weighted sum of the activations
    always_comb begin
        final_d = '0;
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            final_d = final_d + (nn_pkg::sum_t'(act_i[j]) * w_ext[j]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            final_q <= '0;
        end else if (en_i) begin
            final_q <= final_d;
        end
    end

    assign final_o = final_q;

    // target here is the one that travelled with this sum
    assign end_check_o = (final_q == '0) && (target_i == '0);

    // squared error, difference may go negative for a small sum
    always_comb begin
        diff   = signed'(nn_pkg::loss_t'(final_q)) - signed'(nn_pkg::loss_t'(target_i));
        loss_d = nn_pkg::loss_t'(diff * diff);
    end

    // a zero sum leaves the previous loss in place
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            loss_q <= '0;
        end else if (loss_en_i && (final_q != '0)) begin
            loss_q <= loss_d;
        end
    end

    assign loss_o = loss_q;

    a_loss_holds_on_zero: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (loss_en_i && (final_q == '0)) |=> $stable(loss_o)
    ) else $error("loss changed after a zero sum");

endmodule

`default_nettype wire

/* design/weight_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module weight_bank #(
    parameter type entry_t = nn_pkg::weight_t
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  wire logic                  wr_en_i,
    input  wire logic [`NN_ADDR_W-1:0] wr_addr_i,
    input  wire entry_t                wr_data_i,
    output entry_t                     entries_o [1 << `NN_ADDR_W]
);

    localparam int DEPTH = 1 << `NN_ADDR_W;

    entry_t mem_q [DEPTH];

    // one write port, cleared at reset
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int k = 0; k < DEPTH; k++) begin
                mem_q[k] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // every entry visible at once
    assign entries_o = mem_q;

    // a write with X bits would poison every later inference
    a_wr_data_known: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        wr_en_i |-> !$isunknown({wr_addr_i, wr_data_i})
    ) else $error("weight bank write with unknown address or data");

endmodule

`default_nettype wire

/* verif/nn_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nn_consts.svh"

module nn_tb;

    localparam int DONE_TIMEOUT = 10;
    localparam int BURST = 4;
    localparam int BURST_WINDOW = 16;

    typedef logic [`NN_ADDR_W-1:0] addr_t;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                start_i;
    nn_pkg::pixel_vec_t  pixels_i;
    nn_pkg::target_t     target_i;
    logic                hw_wr_en_i;
    logic                ow_wr_en_i;
    addr_t               w_addr_i;
    nn_pkg::hidden_row_t hw_data_i;
    nn_pkg::weight_t     ow_data_i;
    nn_pkg::sum_t        final_o;
    nn_pkg::loss_t       loss_o;
    logic                end_check_o;
    logic                done_o;

    // mirror of the two weight banks
    nn_pkg::hidden_row_t hw_model [`NN_HIDDEN];
    nn_pkg::weight_t     ow_model [`NN_HIDDEN];
    // loss the DUT should be holding
    nn_pkg::loss_t       exp_loss;
    int                  seed;

    nn_top dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .pixels_i    (pixels_i),
        .target_i    (target_i),
        .hw_wr_en_i  (hw_wr_en_i),
        .ow_wr_en_i  (ow_wr_en_i),
        .w_addr_i    (w_addr_i),
        .hw_data_i   (hw_data_i),
        .ow_data_i   (ow_data_i),
        .final_o     (final_o),
        .loss_o      (loss_o),
        .end_check_o (end_check_o),
        .done_o      (done_o)
    );

    always #5 clk_i = ~clk_i;

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("ERR @ %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic nn_pkg::hidden_row_t rand_row();
        nn_pkg::hidden_row_t row;
        for (int i = 0; i < `NN_FANIN; i++) begin
            row[i] = nn_pkg::weight_t'($random(seed));
        end
        return row;
    endfunction

    function automatic nn_pkg::pixel_vec_t rand_pixels();
        nn_pkg::pixel_vec_t pix;
        for (int i = 0; i < `NN_FANIN; i++) begin
            pix[i] = nn_pkg::pixel_t'($random(seed));
        end
        return pix;
    endfunction

    // activation: 15-bit sum of products, scaled down by the shift
    function automatic nn_pkg::act_t model_act(input nn_pkg::pixel_vec_t pix,
                                               input nn_pkg::hidden_row_t row);
        int unsigned acc;
        acc = 0;
        for (int i = 0; i < `NN_FANIN; i++) begin
            acc = acc + 32'(pix[i]) * 32'(row[i]);
        end
        return nn_pkg::act_t'(acc >> `NN_ACT_SHIFT);
    endfunction

    function automatic nn_pkg::sum_t model_sum(input nn_pkg::pixel_vec_t pix);
        int unsigned  acc;
        nn_pkg::act_t act;
        acc = 0;
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            act = model_act(pix, hw_model[j]);
            acc = acc + 32'(act) * 32'(ow_model[j]);
        end
        return nn_pkg::sum_t'(acc);
    endfunction

    // square of a signed difference
    function automatic nn_pkg::loss_t model_loss(input nn_pkg::sum_t sum,
                                                 input nn_pkg::target_t tgt);
        longint diff;
        diff = longint'(sum) - longint'(tgt);
        return nn_pkg::loss_t'(diff * diff);
    endfunction

    // a zero sum leaves the old loss
    task automatic update_exp_loss(input nn_pkg::sum_t sum, input nn_pkg::target_t tgt);
        if (sum != '0) begin
            exp_loss = model_loss(sum, tgt);
        end
    endtask

    task automatic write_hidden_row(input addr_t addr, input nn_pkg::hidden_row_t row);
        w_addr_i   = addr;
        hw_data_i  = row;
        hw_wr_en_i = 1'b1;
        tick();
        hw_wr_en_i = 1'b0;
        hw_model[addr] = row;
    endtask

    task automatic write_out_weight(input addr_t addr, input nn_pkg::weight_t w);
        w_addr_i   = addr;
        ow_data_i  = w;
        ow_wr_en_i = 1'b1;
        tick();
        ow_wr_en_i = 1'b0;
        ow_model[addr] = w;
    endtask

    task automatic load_random_weights();
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            write_hidden_row(addr_t'(j), rand_row());
            write_out_weight(addr_t'(j), nn_pkg::weight_t'($random(seed)));
        end
    endtask

    task automatic check_outputs(input nn_pkg::sum_t exp_sum, input logic exp_end);
        assert (final_o == exp_sum) else
            report_error($sformatf("final_o is %0d, expected %0d", final_o, exp_sum));
        assert (loss_o == exp_loss) else
            report_error($sformatf("loss_o is %0d, expected %0d", loss_o, exp_loss));
        assert (end_check_o == exp_end) else
            report_error($sformatf("end_check_o is %0b, expected %0b", end_check_o, exp_end));
    endtask

    // one start, then wait for done and check the results
    task automatic run_inference(input nn_pkg::pixel_vec_t pix, input nn_pkg::target_t tgt);
        nn_pkg::sum_t exp_sum;
        int           n;
        exp_sum = model_sum(pix);
        update_exp_loss(exp_sum, tgt);
        start_i  = 1'b1;
        pixels_i = pix;
        target_i = tgt;
        tick();
        // target left in place so end_check_o still sees it at done
        start_i = 1'b0;
        n = 0;
        while (!done_o && n < DONE_TIMEOUT) begin
            tick();
            n++;
        end
        if (!done_o) begin
            report_timeout("done_o never arrived after a start");
        end
        check_outputs(exp_sum, (exp_sum == '0) && (tgt == '0));
        tick();
        assert (!done_o) else report_error("done_o high for more than one cycle");
    endtask

    task automatic test_reset_state();
        $display("test: reset state");
        assert (done_o == 1'b0) else report_error("done_o not zero after reset");
        assert (final_o == '0) else report_error("final_o not zero after reset");
        assert (loss_o == '0) else report_error("loss_o not zero after reset");
        assert (end_check_o == 1'b1) else report_error("end_check_o low after reset");
    endtask

    task automatic test_single_inference();
        $display("test: single inference");
        load_random_weights();
        run_inference(rand_pixels(), nn_pkg::target_t'($random(seed)));
    endtask

    task automatic test_zero_sum();
        $display("test: zero sum");
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            write_out_weight(addr_t'(j), '0);
        end
        // zero target first, then a nonzero one
        run_inference(rand_pixels(), nn_pkg::target_t'(0));
        run_inference(rand_pixels(), nn_pkg::target_t'(5));
    endtask

    task automatic test_back_to_back();
        nn_pkg::pixel_vec_t pix [BURST];
        nn_pkg::target_t    tgt [BURST];
        nn_pkg::sum_t       sums [BURST];
        int                 k;
        int                 j;
        $display("test: back-to-back starts");
        for (int i = 0; i < `NN_HIDDEN; i++) begin
            write_out_weight(addr_t'(i), nn_pkg::weight_t'($random(seed)));
        end
        tgt[0] = 4'd3;
        tgt[1] = 4'd0;
        tgt[2] = 4'd9;
        tgt[3] = 4'd15;
        for (int i = 0; i < BURST; i++) begin
            pix[i]  = rand_pixels();
            sums[i] = model_sum(pix[i]);
        end
        k = 0;
        for (int cyc = 0; cyc < BURST_WINDOW; cyc++) begin
            if (done_o) begin
                assert (k < BURST) else report_error("more done_o pulses than starts");
                update_exp_loss(sums[k], tgt[k]);
                // the following start has already replaced the sum register
                j = (k + 1 < BURST) ? k + 1 : k;
                check_outputs(sums[j], (sums[j] == '0) && (tgt[j] == '0));
                k++;
            end
            if (cyc < BURST) begin
                start_i  = 1'b1;
                pixels_i = pix[cyc];
                target_i = tgt[cyc];
            end else begin
                start_i = 1'b0;
            end
            tick();
        end
        if (k < BURST) begin
            report_timeout("done_o pulsed fewer times than there were starts");
        end
    endtask

    task automatic test_weight_rewrite();
        $display("test: weight rewrite");
        write_hidden_row(addr_t'(3), rand_row());
        write_out_weight(addr_t'(6), nn_pkg::weight_t'($random(seed)));
        run_inference(rand_pixels(), nn_pkg::target_t'(7));
    endtask

    initial begin
        seed       = 84;
        rst_i      = 1'b0;
        start_i    = 1'b0;
        pixels_i   = '0;
        target_i   = '0;
        hw_wr_en_i = 1'b0;
        ow_wr_en_i = 1'b0;
        w_addr_i   = '0;
        hw_data_i  = '0;
        ow_data_i  = '0;
        exp_loss   = '0;
        for (int j = 0; j < `NN_HIDDEN; j++) begin
            hw_model[j] = '0;
            ow_model[j] = '0;
        end

        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        test_reset_state();
        test_single_inference();
        test_zero_sum();
        test_back_to_back();
        test_weight_rewrite();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
